// File: logic/seg_pkg.sv
package seg_pkg;

    localparam int NUM_DIGITS = 8;                 // Digits on the board

    typedef logic [7:0]            digit_code_t;   // Raw code of one digit
    typedef logic [7:0]            seg_pattern_t;  // Bit 0 is segment a, bit 7 is dp
    typedef logic [2:0]            digit_sel_t;    // Index of the lit digit
    typedef logic [NUM_DIGITS-1:0] digit_mask_t;   // One bit per digit
    typedef logic [7:0]            apb_addr_t;
    typedef logic [31:0]           apb_data_t;

    typedef struct packed {
        logic      psel;
        logic      penable;
        logic      pwrite;
        apb_addr_t paddr;
        apb_data_t pwdata;
    } apb_req_t;

    typedef struct packed {
        apb_data_t prdata;
        logic      pready;
        logic      pslverr;
    } apb_rsp_t;

    typedef struct packed {
        apb_data_t   digits_lo;                    // Digits 0..3, digit 0 in bits 7:0
        apb_data_t   digits_hi;                    // Digits 4..7, digit 4 in bits 7:0
        logic        enable;
        digit_mask_t dp_mask;
    } disp_cfg_t;

    localparam apb_addr_t REG_DIGITS_LO = 8'h00;
    localparam apb_addr_t REG_DIGITS_HI = 8'h04;
    localparam apb_addr_t REG_CTRL      = 8'h08;

    localparam int CTRL_EN_BIT = 0;                // Display enable in CTRL
    localparam int CTRL_DP_LSB = 8;                // Start of dp mask in CTRL
    localparam int SEG_DP      = 7;                // Decimal point bit of a pattern

    // Hex glyphs, active high, segment g in bit 6
    function automatic seg_pattern_t seg_decode(input digit_code_t code);
        seg_pattern_t pat;
        case (code)
            8'h00:   pat = 8'h3F;                  // 0
            8'h01:   pat = 8'h06;                  // 1
            8'h02:   pat = 8'h5B;                  // 2
            8'h03:   pat = 8'h4F;                  // 3
            8'h04:   pat = 8'h66;                  // 4
            8'h05:   pat = 8'h6D;                  // 5
            8'h06:   pat = 8'h7D;                  // 6
            8'h07:   pat = 8'h07;                  // 7
            8'h08:   pat = 8'h7F;                  // 8
            8'h09:   pat = 8'h6F;                  // 9
            8'h0A:   pat = 8'h77;                  // A
            8'h0B:   pat = 8'h7C;                  // Lower case b
            8'h0C:   pat = 8'h39;                  // C
            8'h0D:   pat = 8'h5E;                  // Lower case d
            8'h0E:   pat = 8'h79;                  // E
            8'h0F:   pat = 8'h71;                  // F
            default: pat = 8'h00;                  // Blank
        endcase
        return pat;
    endfunction

endpackage

// File: logic/apb_display_regs.sv
`timescale 1ns/1ns

module apb_display_regs import seg_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  apb_req_t  apb_req,
    output apb_rsp_t  apb_rsp,
    output disp_cfg_t cfg
);

    logic        access;                           // Access phase of a transfer
    logic        wr_en;
    logic        hit_lo;
    logic        hit_hi;
    logic        hit_ctrl;
    logic        mapped;

    apb_data_t   digits_lo;
    apb_data_t   digits_hi;
    logic        enable;
    digit_mask_t dp_mask;

    apb_data_t   ctrl_rd;                          // CTRL as seen on readback
    apb_data_t   rd_data;

    assign access = apb_req.psel && apb_req.penable;
    assign wr_en  = access && apb_req.pwrite;

    // Word addresses only, anything else is unmapped
    assign hit_lo   = (apb_req.paddr == REG_DIGITS_LO);
    assign hit_hi   = (apb_req.paddr == REG_DIGITS_HI);
    assign hit_ctrl = (apb_req.paddr == REG_CTRL);
    assign mapped   = hit_lo || hit_hi || hit_ctrl;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            digits_lo <= '0;
            digits_hi <= '0;
        end else if (wr_en) begin
            if (hit_lo)
                digits_lo <= apb_req.pwdata;       // Full word
            if (hit_hi)
                digits_hi <= apb_req.pwdata;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            enable  <= 1'b0;                       // Display off after reset
            dp_mask <= '0;
        end else if (wr_en && hit_ctrl) begin
            enable  <= apb_req.pwdata[CTRL_EN_BIT];
            dp_mask <= apb_req.pwdata[CTRL_DP_LSB +: NUM_DIGITS];
        end
    end

    always_comb begin
        ctrl_rd                           = '0;    // Unused bits read as zero
        ctrl_rd[CTRL_EN_BIT]              = enable;
        ctrl_rd[CTRL_DP_LSB +: NUM_DIGITS] = dp_mask;
    end

    always_comb begin
        if (hit_lo)
            rd_data = digits_lo;
        else if (hit_hi)
            rd_data = digits_hi;
        else if (hit_ctrl)
            rd_data = ctrl_rd;
        else
            rd_data = '0;                          // Unmapped reads give zero
    end

    assign apb_rsp.prdata  = rd_data;
    assign apb_rsp.pready  = 1'b1;                 // No wait states
    assign apb_rsp.pslverr = access && !mapped;

    assign cfg = '{
        digits_lo: digits_lo,
        digits_hi: digits_hi,
        enable:    enable,
        dp_mask:   dp_mask
    };

    // Access phase must follow a setup phase with psel held
    penable_after_setup: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(apb_req.penable) |-> apb_req.psel && $past(apb_req.psel && !apb_req.penable)
    ) else $error("penable rose without a setup phase");

    // Every access phase completes in the same cycle
    access_completes: assert property (
        @(posedge clk) disable iff (!rst_n)
        access |-> apb_rsp.pready
    ) else $error("pready low in access phase");

endmodule

// File: logic/scan_timer.sv
`timescale 1ns/1ns

module scan_timer import seg_pkg::*; #(
    parameter int SCAN_PERIOD = 50000              // Clocks per digit, at least 2
) (
    input  logic       clk,
    input  logic       rst_n,
    output digit_sel_t digit_idx
);

    localparam int               CNT_W    = $clog2(SCAN_PERIOD);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(SCAN_PERIOD - 1);

    logic [CNT_W-1:0] cycle_cnt;
    logic             scan_step;                   // One cycle pulse per digit slot

    assign scan_step = (cycle_cnt == CNT_LAST);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cycle_cnt <= '0;
        end else if (scan_step) begin
            cycle_cnt <= '0;
        end else begin
            cycle_cnt <= cycle_cnt + 1'b1;
        end
    end

    // Step enable instead of a divided clock, so everything stays on clk
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            digit_idx <= '0;
        end else if (scan_step) begin
            digit_idx <= digit_idx + 3'd1;         // Wraps 7 to 0
        end
    end

endmodule

// File: logic/seg_digit_driver.sv
`timescale 1ns/1ns

module seg_digit_driver import seg_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  disp_cfg_t    cfg,
    input  digit_sel_t   digit_idx,
    output digit_mask_t  seg_en,
    output seg_pattern_t seg_out
);

    apb_data_t    digit_word;                      // Register holding the active digit
    digit_code_t  digit_code;
    seg_pattern_t digit_pattern;
    digit_mask_t  digit_onehot;

    // Top index bit picks the register, the low two pick the byte
    assign digit_word = digit_idx[2] ? cfg.digits_hi : cfg.digits_lo;
    assign digit_code = digit_word[{digit_idx[1:0], 3'b000} +: 8];

    always_comb begin
        digit_pattern         = seg_decode(digit_code);
        digit_pattern[SEG_DP] = cfg.dp_mask[digit_idx];  // Dp on top of the glyph
    end

    assign digit_onehot = digit_mask_t'(1) << digit_idx;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            seg_en  <= '0;
            seg_out <= '0;
        end else if (cfg.enable) begin
            seg_en  <= digit_onehot;
            seg_out <= digit_pattern;
        end else begin
            seg_en  <= '0;                         // Display dark
            seg_out <= '0;
        end
    end

    // Never more than one digit lit
    seg_en_onehot0: assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0(seg_en)
    ) else $error("more than one digit enabled");

endmodule

// File: logic/seg_display_top.sv
`timescale 1ns/1ns

module seg_display_top import seg_pkg::*; #(
    parameter int SCAN_PERIOD = 50000              // Clocks each digit stays lit
) (
    input  logic         clk,
    input  logic         rst_n,
    input  apb_req_t     apb_req,
    output apb_rsp_t     apb_rsp,
    output digit_mask_t  seg_en,
    output seg_pattern_t seg_out
);

    disp_cfg_t  cfg;                               // Register contents for the driver
    digit_sel_t digit_idx;                         // Active digit from the timer

    apb_display_regs u_apb_display_regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .cfg     (cfg)
    );

    scan_timer #(
        .SCAN_PERIOD (SCAN_PERIOD)
    ) u_scan_timer (
        .clk       (clk),
        .rst_n     (rst_n),
        .digit_idx (digit_idx)
    );

    // Registered outputs, so a write shows up two cycles after its access phase
    seg_digit_driver u_seg_digit_driver (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg       (cfg),
        .digit_idx (digit_idx),
        .seg_en    (seg_en),
        .seg_out   (seg_out)
    );

endmodule

// File: sim/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int CLK_PERIOD   = 8,                // ns
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1;                           // Release just after an edge
    end

endmodule

// File: sim/tb_seg_display.sv
`timescale 1ns/1ns

module tb_seg_display import seg_pkg::*; ();

    localparam int          SCAN_PERIOD   = 6;
    localparam int          CLK_PERIOD    = 8;
    localparam int          DECODE_ROUNDS = 10;
    localparam apb_data_t   CTRL_MASK     = 32'h0000_FF01;  // Bits that CTRL stores
    localparam logic [31:0] LFSR_TAPS     = 32'h8020_0003;

    // Cycle budget per test, one transfer costs about three cycles
    localparam int XFER        = 3;
    localparam int SLOT_ROUND  = NUM_DIGITS * SCAN_PERIOD;
    localparam int T_RESET     = 10 + 3 * XFER;
    localparam int T_READBACK  = 3 * 6 * XFER;
    localparam int T_SCAN      = XFER + 20 * SCAN_PERIOD;
    localparam int T_DECODE    = DECODE_ROUNDS * (3 * XFER + SLOT_ROUND);
    localparam int T_DISABLE   = XFER + 2 * SLOT_ROUND + 2;
    localparam int T_BAD       = 6 * XFER + SLOT_ROUND;
    localparam int TEST_CYCLES = T_RESET + T_READBACK + T_SCAN + T_DECODE + T_DISABLE + T_BAD;
    localparam int TIMEOUT_NS  = (TEST_CYCLES + 100) * CLK_PERIOD;

    // Hex glyphs 0 to F, digit 0 in the low byte
    localparam logic [127:0] GLYPHS = {
        8'h71, 8'h79, 8'h5E, 8'h39, 8'h7C, 8'h77, 8'h6F, 8'h7F,
        8'h07, 8'h7D, 8'h6D, 8'h66, 8'h4F, 8'h5B, 8'h06, 8'h3F
    };

    logic         clk;
    logic         rst_n;
    apb_req_t     apb_req;
    apb_rsp_t     apb_rsp;
    digit_mask_t  seg_en;
    seg_pattern_t seg_out;

    string        test_name = "init";
    logic [31:0]  lfsr_state = 32'h504a;

    // Shadow registers and scan model
    apb_data_t    sh_lo     = '0;
    apb_data_t    sh_hi     = '0;
    logic         sh_en     = 1'b0;
    digit_mask_t  sh_dp     = '0;
    digit_sel_t   model_idx = '0;
    int           model_cnt = 0;
    digit_mask_t  exp_en    = '0;
    seg_pattern_t exp_out   = '0;

    tb_clock_gen #(
        .CLK_PERIOD   (CLK_PERIOD),
        .RESET_CYCLES (5)
    ) u_tb_clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    seg_display_top #(
        .SCAN_PERIOD (SCAN_PERIOD)
    ) u_seg_display_top (
        .clk     (clk),
        .rst_n   (rst_n),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .seg_en  (seg_en),
        .seg_out (seg_out)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ LFSR_TAPS) : (state >> 1);
    endfunction

    // One LFSR step per bit taken
    function automatic apb_data_t random_bits(input int count);
        apb_data_t value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value      = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return value;
    endfunction

    // Four 5-bit codes, so about half are blank
    function automatic apb_data_t random_digits();
        apb_data_t word;
        word = '0;
        for (int d = 0; d < 4; d++)
            word[d * 8 +: 8] = digit_code_t'(random_bits(5));
        return word;
    endfunction

    function automatic seg_pattern_t glyph_of(input digit_code_t code);
        if (code > 8'h0F)
            return '0;                             // Blank
        return GLYPHS[{code[3:0], 3'b000} +: 8];
    endfunction

    // Expected {seg_en, seg_out} one cycle after this state
    function automatic logic [15:0] expected_outputs(
        input apb_data_t   lo,
        input apb_data_t   hi,
        input logic        en,
        input digit_mask_t dp,
        input digit_sel_t  idx
    );
        int           slot;
        digit_code_t  code;
        seg_pattern_t pat;
        digit_mask_t  lit;
        if (!en)
            return 16'h0000;
        slot   = int'(idx[1:0]) * 8;
        code   = idx[2] ? hi[slot +: 8] : lo[slot +: 8];
        pat    = glyph_of(code);
        pat[7] = dp[idx];                          // Decimal point on top
        lit    = digit_mask_t'(1) << idx;
        return {lit, pat};
    endfunction

    task automatic stop_on_failure();
        $display("RESULT: FAIL");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("MISMATCH test=%s %s expected %h actual %h",
                     test_name, what, expected, actual);
            stop_on_failure();
        end
    endtask

    task automatic next_drive_point();
        @(posedge clk);
        #1;
    endtask

    task automatic write_and_check(input apb_addr_t addr, input apb_data_t data,
                                   input logic exp_err);
        logic err;
        logic rdy;
        next_drive_point();
        apb_req.psel    = 1'b1;                    // Setup phase
        apb_req.penable = 1'b0;
        apb_req.pwrite  = 1'b1;
        apb_req.paddr   = addr;
        apb_req.pwdata  = data;
        next_drive_point();
        apb_req.penable = 1'b1;                    // Access phase
        @(negedge clk);
        err = apb_rsp.pslverr;
        rdy = apb_rsp.pready;
        next_drive_point();
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = 1'b0;
        check_value($sformatf("pslverr on write to %h", addr), 32'(exp_err), 32'(err));
        check_value($sformatf("pready on write to %h", addr), 32'd1, 32'(rdy));
    endtask

    task automatic read_and_check(input apb_addr_t addr, input apb_data_t exp_data,
                                  input logic exp_err);
        apb_data_t data;
        logic      err;
        logic      rdy;
        next_drive_point();
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = 1'b0;
        apb_req.paddr   = addr;
        next_drive_point();
        apb_req.penable = 1'b1;
        @(negedge clk);                            // prdata valid mid access phase
        data = apb_rsp.prdata;
        err  = apb_rsp.pslverr;
        rdy  = apb_rsp.pready;
        next_drive_point();
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
        check_value($sformatf("prdata at %h", addr), exp_data, data);
        check_value($sformatf("pslverr on read of %h", addr), 32'(exp_err), 32'(err));
        check_value($sformatf("pready on read of %h", addr), 32'd1, 32'(rdy));
    endtask

    // Slot order and slot length, counted independently of the model
    task automatic verify_scan_rounds(input int rounds);
        digit_mask_t prev;
        digit_mask_t want_en;
        digit_sel_t  want;
        int          held;
        want = '0;
        @(negedge clk);
        while (seg_en == '0)
            @(negedge clk);                        // Display comes on, maybe mid-slot
        prev = seg_en;
        while (seg_en == prev)
            @(negedge clk);                        // First whole slot starts here
        assert ($onehot(seg_en)) else begin
            $display("seg_en is not one-hot at the start of a digit slot");
            stop_on_failure();
        end
        for (int i = 0; i < NUM_DIGITS; i++)
            if (seg_en[i])
                want = digit_sel_t'(i);
        for (int step = 0; step < rounds * NUM_DIGITS; step++) begin
            want_en = digit_mask_t'(1) << want;
            check_value("scan seg_en", 32'(want_en), 32'(seg_en));
            prev = seg_en;
            held = 0;
            do begin
                held++;
                @(negedge clk);
            end while (seg_en == prev);
            check_value("slot length", 32'(SCAN_PERIOD), 32'(held));
            want = want + 3'd1;                    // Wraps 7 to 0
        end
    endtask

    // Reference model, stepped on the same edges as the DUT
    always @(posedge clk) begin
        if (!rst_n) begin
            sh_lo     = '0;
            sh_hi     = '0;
            sh_en     = 1'b0;
            sh_dp     = '0;
            model_idx = '0;
            model_cnt = 0;
            exp_en    = '0;
            exp_out   = '0;
        end else begin
            {exp_en, exp_out} = expected_outputs(sh_lo, sh_hi, sh_en, sh_dp, model_idx);
            if (apb_req.psel && apb_req.penable && apb_req.pwrite) begin
                case (apb_req.paddr)
                    REG_DIGITS_LO: sh_lo = apb_req.pwdata;
                    REG_DIGITS_HI: sh_hi = apb_req.pwdata;
                    REG_CTRL: begin
                        sh_en = apb_req.pwdata[0];
                        sh_dp = apb_req.pwdata[15:8];
                    end
                    default: ;                     // Unmapped, nothing stored
                endcase
            end
            if (model_cnt == SCAN_PERIOD - 1) begin
                model_cnt = 0;
                model_idx = model_idx + 3'd1;
            end else begin
                model_cnt++;
            end
        end
    end

    // Outputs are stable at the falling edge
    always @(negedge clk) begin
        if (rst_n) begin
            check_value("seg_en", 32'(exp_en), 32'(seg_en));
            check_value("seg_out", 32'(exp_out), 32'(seg_out));
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: tests did not finish within %0d ns", TIMEOUT_NS);
        stop_on_failure();
    end

    initial begin
        apb_data_t   lo;
        apb_data_t   hi;
        apb_data_t   ctrl;
        digit_mask_t dp;

        apb_req = '0;
        lo      = '0;
        hi      = '0;
        @(posedge rst_n);

        test_name = "reset_state";
        repeat (3) @(negedge clk);
        check_value("seg_en after reset", 32'd0, 32'(seg_en));
        check_value("seg_out after reset", 32'd0, 32'(seg_out));
        read_and_check(REG_DIGITS_LO, 32'd0, 1'b0);
        read_and_check(REG_DIGITS_HI, 32'd0, 1'b0);
        read_and_check(REG_CTRL, 32'd0, 1'b0);

        test_name = "readback";
        repeat (3) begin
            lo   = random_bits(32);
            hi   = random_bits(32);
            ctrl = random_bits(32);
            write_and_check(REG_DIGITS_LO, lo, 1'b0);
            write_and_check(REG_DIGITS_HI, hi, 1'b0);
            write_and_check(REG_CTRL, ctrl, 1'b0);
            read_and_check(REG_DIGITS_LO, lo, 1'b0);
            read_and_check(REG_DIGITS_HI, hi, 1'b0);
            read_and_check(REG_CTRL, ctrl & CTRL_MASK, 1'b0);
        end

        test_name = "scan_order";
        dp = digit_mask_t'(random_bits(8));
        write_and_check(REG_CTRL, {16'h0000, dp, 8'h01}, 1'b0);
        verify_scan_rounds(2);

        test_name = "decode";
        for (int r = 0; r < DECODE_ROUNDS; r++) begin
            lo = random_digits();
            hi = random_digits();
            dp = digit_mask_t'(random_bits(8));
            write_and_check(REG_DIGITS_LO, lo, 1'b0);  // Lands mid-scan
            write_and_check(REG_DIGITS_HI, hi, 1'b0);
            write_and_check(REG_CTRL, {16'h0000, dp, 8'h01}, 1'b0);
            repeat (SLOT_ROUND) @(posedge clk);
        end

        test_name = "disable";
        dp = digit_mask_t'(random_bits(8));
        write_and_check(REG_CTRL, {16'h0000, dp, 8'h00}, 1'b0);
        repeat (2 * SLOT_ROUND) @(posedge clk);
        @(negedge clk);
        check_value("seg_en while disabled", 32'd0, 32'(seg_en));

        test_name = "bad_address";
        ctrl = {16'h0000, dp, 8'h01};
        write_and_check(REG_CTRL, ctrl, 1'b0);
        write_and_check(8'h0C, random_bits(32), 1'b1);
        read_and_check(8'h0C, 32'd0, 1'b1);
        read_and_check(REG_DIGITS_LO, lo, 1'b0);
        read_and_check(REG_DIGITS_HI, hi, 1'b0);
        read_and_check(REG_CTRL, ctrl, 1'b0);
        repeat (SLOT_ROUND) @(posedge clk);

        test_name = "done";
        $display("RESULT: PASS");
        $finish;
    end

endmodule

// File: vlog.f
logic/seg_pkg.sv
logic/apb_display_regs.sv
logic/scan_timer.sv
logic/seg_digit_driver.sv
logic/seg_display_top.sv
sim/tb_clock_gen.sv
sim/tb_seg_display.sv

// File: Makefile
# Verilator build and run of the seven-segment display testbench

VERILATOR ?= verilator
TOP       ?= tb_seg_display
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns -j $(JOBS)

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@grep -q "RESULT: PASS" $(LOG) || { echo "No pass result in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
